// File: fetch_top.sv
`default_nettype none

`include "icache_consts.svh"

module fetch_top (
	input logic clk,
	input logic rst,
	input logic [`ICACHE_ADDR_W-1:0] pc,
	input logic req_valid,
	input logic id_ready,
	input logic flush,
	output icache_pkg::inst_t inst,
	output logic inst_valid
);

	import icache_pkg::*;

	// refill path between cache and backing memory
	logic [`ICACHE_ADDR_W-1:0] mem_addr;
	line_t mem_line;

	icache u_icache (
		.clk(clk),
		.rst(rst),
		.pc(pc),
		.req_valid(req_valid),
		.id_ready(id_ready),
		.flush(flush),
		.mem_line(mem_line),
		.mem_addr(mem_addr),
		.inst(inst),
		.inst_valid(inst_valid)
	);

	// read-only program store
	line_memory u_mem (
		.addr(mem_addr),
		.line(mem_line)
	);

endmodule

`default_nettype wire

// File: icache.sv
`default_nettype none

`include "icache_consts.svh"

module icache (
	input logic clk,
	input logic rst,
	input logic [`ICACHE_ADDR_W-1:0] pc,
	input logic req_valid,
	input logic id_ready,
	input logic flush,
	input icache_pkg::line_t mem_line,
	output logic [`ICACHE_ADDR_W-1:0] mem_addr,
	output icache_pkg::inst_t inst,
	output logic inst_valid
);

	import icache_pkg::*;

	// request address fields
	index_t index;
	tag_t tag;
	logic [`ICACHE_WORD_SEL_W-1:0] word;

	// lookup and control
	way_mask_t way_hit;
	way_mask_t refill_mask;
	way_mask_t victim_q;
	logic accept;
	logic miss;

	// per-way SRAM controls and data
	logic [`ICACHE_WAYS-1:0] cen_n;
	logic [`ICACHE_WAYS-1:0] wen_n;
	line_t dout [`ICACHE_WAYS];

	// request stage registers
	way_mask_t hit_q;
	line_t bypass_q;
	logic [`ICACHE_WORD_SEL_W-1:0] word_q;
	logic inst_valid_q;

	// word select and stall hold
	line_t line_sel;
	inst_t inst_sel;
	hold_state_e hold_q;
	inst_t hold_inst_q;

	assign index = pc[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
	assign tag = pc[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
	assign word = pc[`ICACHE_OFFSET_W-1 -: `ICACHE_WORD_SEL_W];

	// whole line comes back from memory in the same cycle
	assign mem_addr = pc;

	assign accept = req_valid && id_ready;
	assign miss = accept && (way_hit == '0);

	// victim way takes the refill on a miss
	assign refill_mask = miss ? victim_q : '0;

	icache_tags u_tags (
		.clk(clk),
		.rst(rst),
		.index(index),
		.tag(tag),
		.refill_mask(refill_mask),
		.way_hit(way_hit)
	);

	genvar w;
	for (w = 0; w < `ICACHE_WAYS; w++) begin : g_way
		// hit reads its own way, miss writes only the victim
		assign cen_n[w] = !(accept && (way_hit[w] || refill_mask[w]));
		assign wen_n[w] = !refill_mask[w];

		sram_way u_sram (
			.clk(clk),
			.cen_n(cen_n[w]),
			.wen_n(wen_n[w]),
			.addr(index),
			.din(mem_line),
			.dout(dout[w])
		);
	end

	// rotating one-hot victim pointer, frozen while stalled
	always_ff @(posedge clk) begin
		if (rst) begin
			victim_q <= way_mask_t'(1);
		end else if (id_ready) begin
			victim_q <= {victim_q[`ICACHE_WAYS-2:0], victim_q[`ICACHE_WAYS-1]};
		end
	end

	// control side of the request stage
	always_ff @(posedge clk) begin
		if (rst) begin
			hit_q <= '0;
			inst_valid_q <= 1'b0;
		end else if (id_ready) begin
			hit_q <= accept ? way_hit : '0;
			// flushed request still refills but delivers nothing
			inst_valid_q <= accept && !flush;
		end
	end

	// payload side of the request stage
	always_ff @(posedge clk) begin
		if (id_ready) begin
			bypass_q <= mem_line;
			word_q <= word;
		end
	end

	// hit way's SRAM output, or the bypassed line on a miss
	always_comb begin
		line_sel = bypass_q;
		for (int i = 0; i < `ICACHE_WAYS; i++) begin
			if (hit_q[i]) begin
				line_sel = dout[i];
			end
		end
	end

	assign inst_sel = line_sel[word_q * `ICACHE_INST_W +: `ICACHE_INST_W];

	// capture on the first stall cycle, release when decode is ready again
	always_ff @(posedge clk) begin
		if (rst) begin
			hold_q <= HOLD_IDLE;
		end else begin
			case (hold_q)
				HOLD_IDLE: begin
					if (!id_ready) begin
						hold_q <= HOLD_CAPTURED;
					end
				end
				HOLD_CAPTURED: begin
					if (id_ready) begin
						hold_q <= HOLD_IDLE;
					end
				end
				default: hold_q <= HOLD_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (hold_q == HOLD_IDLE && !id_ready) begin
			hold_inst_q <= inst_sel;
		end
	end

	assign inst = (hold_q == HOLD_CAPTURED) ? hold_inst_q : inst_sel;
	assign inst_valid = inst_valid_q;

endmodule

`default_nettype wire

// File: icache_consts.svh
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// fetch address width in bits
`define ICACHE_ADDR_W 32

// byte offset inside one 16-byte line
`define ICACHE_OFFSET_W 4

// 16 sets
`define ICACHE_INDEX_W 4
`define ICACHE_SETS (1 << `ICACHE_INDEX_W)

// associativity
`define ICACHE_WAYS 4

// line and instruction widths
`define ICACHE_LINE_W 128
`define ICACHE_INST_W 32

// word select bits, four words per line
`define ICACHE_WORD_SEL_W $clog2(`ICACHE_LINE_W / `ICACHE_INST_W)

// backing memory depth in lines, 2 KB total
`define ICACHE_MEM_LINES 128

// everything above index and offset is tag
`define ICACHE_TAG_W (`ICACHE_ADDR_W - `ICACHE_INDEX_W - `ICACHE_OFFSET_W)

`endif

// File: icache_pkg.sv
`default_nettype none

`include "icache_consts.svh"

package icache_pkg;

	// address fields
	typedef logic [`ICACHE_TAG_W-1:0] tag_t;
	typedef logic [`ICACHE_INDEX_W-1:0] index_t;

	// data words
	typedef logic [`ICACHE_LINE_W-1:0] line_t;
	typedef logic [`ICACHE_INST_W-1:0] inst_t;

	// one bit per way, one-hot or zero
	typedef logic [`ICACHE_WAYS-1:0] way_mask_t;

	// output hold register during decode stalls
	typedef enum logic {
		HOLD_IDLE,
		HOLD_CAPTURED
	} hold_state_e;

endpackage

`default_nettype wire

// File: icache_tags.sv
`default_nettype none

`include "icache_consts.svh"

module icache_tags (
	input logic clk,
	input logic rst,
	input icache_pkg::index_t index,
	input icache_pkg::tag_t tag,
	input icache_pkg::way_mask_t refill_mask,
	output icache_pkg::way_mask_t way_hit
);

	import icache_pkg::*;

	// tag storage with one array per way
	tag_t tag_mem [`ICACHE_WAYS][`ICACHE_SETS];

	// valid bits with one vector per way
	logic [`ICACHE_SETS-1:0] valid_q [`ICACHE_WAYS];

	// valid bits clear on reset and set on refill
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < `ICACHE_WAYS; w++) begin
				valid_q[w] <= '0;
			end
		end else begin
			for (int w = 0; w < `ICACHE_WAYS; w++) begin
				// refill marks the victim way valid
				if (refill_mask[w]) begin
					valid_q[w][index] <= 1'b1;
				end
			end
		end
	end

	// tag write for the masked way
	always_ff @(posedge clk) begin
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			if (refill_mask[w]) begin
				tag_mem[w][index] <= tag;
			end
		end
	end

	// per-way compare at the requested set
	always_comb begin
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			way_hit[w] = valid_q[w][index] && (tag_mem[w][index] == tag);
		end
	end

endmodule

`default_nettype wire

// File: line_memory.sv
`default_nettype none

`include "icache_consts.svh"

module line_memory (
	input logic [`ICACHE_ADDR_W-1:0] addr,
	output icache_pkg::line_t line
);

	import icache_pkg::*;

	// line number bits that fit the memory
	localparam int MEM_IDX_W = $clog2(`ICACHE_MEM_LINES);

	// program image, one 128-bit line per hex row
	line_t mem [`ICACHE_MEM_LINES];

	logic [MEM_IDX_W-1:0] line_idx;

	initial begin
		$readmemh("program.hex", mem);
	end

	// drop the byte offset, upper address bits wrap around
	assign line_idx = addr[`ICACHE_OFFSET_W +: MEM_IDX_W];

	// no latency, the cache refills in the request cycle
	assign line = mem[line_idx];

endmodule

`default_nettype wire

// File: list.f
+incdir+.
icache_pkg.sv
sram_way.sv
icache_tags.sv
icache.sv
line_memory.sv
fetch_top.sv
tb_checker.sv
tb_fetch.sv

// File: program.hex
// one 128-bit line per row, line 0 first
// word 0 of a line is the rightmost 8 hex digits
3a7f09c2e1b45d800c9e6f1372d8a4b5
91c04e7d5b2a83f6d06e1c9a4f73b208
0e8d52a1c7f3964b2b15e8d0a96c47f3
f4a1b8036d92e75c18c05f3ab7e4d926
6c3e91f5a04d27b8e59a1c63d28f70b4
b7d24a06193ef5c8c6a8d1e7405b92f3
25e6c8b9f1047a3d8d3b6e0c71a5f429
de91075ac3b86e2450f4c9a1e72d38b6
4b82f61d97c5a03e0a6e3d58c2b19f74
a09dc5e348f1b2671c7b40e9f5a6832d
7f1e3b86d2c40a95e3952fd07b6c18a4
12c7a9e0b5d84f366e08b31ca7f95d42
c58b0f24e96d173a3fa1d7850c2e6b9b
8ae4617cd3b09f258b72c04e1d96a3f5
e3f9d2487a15c06b54c8e91f0b3a7d62
09b6a3d5f2e7184cd1e45b0a8c7f2936
b1d07e9c4a6352f8713cf8e2d45a90b6
5c2a48f3e0b97d162be9d41a6f83c057
f6e81b3592d4a07c9c05e7b24a1f638d
384f6ad0c1e9b257e07a2c9f53b8d146
a72c5e18f94b03d6469d81b7e2c05fa3
d30b9f62574ae18c85f1c6a0b9d4273e
6e95c7b12f08d4a31b28e57dc6a3f094
0f47ad29e83c6b15c4b693e0718d5af2
92d8e04b6a17f3c55ae2f8c3d09b7461
cb6137f80e5d9a2417f5a4d69b2ce083
47a0e9dc3b82615fe8c17b5204fa9d36
e8fc2653d71b40a92d93065fa8e1c7b4
1da59b0e4c7f382673e8dc4a15b6f029
76b3f18a95e02cd4b04a691fe27d853c
af0e47d3281cb965fc7d2e0859a3416b
3492cb6df5a71e080b1fa3d7c84e9625
c9e75a0812d64fb3685b1cf4307ae9d2
5b1d83f6e9a02c7491c6e7b52fd84a30
e60a2c9d47bf158324f5098ec1a37db6
0873fbe1ac526d49da28c53b76e014f9
bd459c72e031a8f64e7b16a09c52f38d
2ac18e504f96d7b3a3f94cd2581e6b07
715f63a9d8e20c4b098d2b74e6fa15c3
ce3a0db6815f94e272e64f1bad0389c5
f82b74e5c60d391a1d5a90c83bf7e26f
63d95f1ba48ce2708c3fe6a91672d05b
9e0c1a874db37f56e574bd306a8c9f12
04b8ed39f72a56c15f1a3c8ed4096be7
ba763c0251e8df4930d8f7146c2ba5e9
58fe91d7093c4ab2a64275fb8e1d03c6
d2149ba6e7f5803c7b89da3c02e45f18
81a3f05c3e6b2d97c92f064da75b18e3
ef672d93b401ca5826c3b9e7f0d1a45b
3c0bd87e62a59f14f40e857b1c93d6a2
a54e29b1d8f73c060d975c23be6a40f8
1fb7c6402a9ed35b8e1a4f96c03b72d5
7692e3fdb51c084a57cd31e89f24ab60
c40f8a15679dbe23e3ab92c04d75f81e
2e8150c7fa34d69b9b640d5e28f1c37a
95dc38aec06b2f4712f87a39e5c04db6
0b7a64f29d15e83c6459e1d2a3b87f0c
e6c31df58a0e47b2c1b04f6872d95ae3
4a2ebc0917f6d35838d6a5f0bc1e2479
d78519b4e3a20fc6a27c3e1d49f058b5
6f39e2a0c5b7148d5e83b9f64d20a71c
b0d4f76e129ac53b07fe48a1c36bd295
19af03c86e4d72b5f6a1d529e0c4873d
ea5d6b3147f09c2864c70e8b9fa531d2
8317ce5fb20a6d94bd2b9f4716e8c05a
5ce82a76d94f03b12b95c6d0e47af318
f27b40d93ac16e8591e37ab5c08d2f64
3ed69f1b085ca72473fa052e6b9d14c8
a9038c6e5f2bd71ecd6e81a74320fb59
6841de2b97c53af0085c3f9bde71a426
c1fa7305e68b29d45a07e4c319b6d82f
2d6b958a3c0fe471e69d2b6850fc731a
9b27e1c4d3568fa04f18a0d7c25e96b3
05c89f63ab7e142db3e7596ce8a0d241
dea4037f16b9c58217a26e3d4bc9f085
7a3f6cd28e1504b9c64db1a85f2703ec
b8e01f5793dca6427b50c924ed16a83f
42c95a8e0f7d631b9e8b37f1a52dc460
e1370b6c4a92fd852c1f94d630e7b5a8
6d5ef294b07c18a3f39a6805c74e2d1b
9c82a41fe53b706d047dc5b29a1f8e36
1ea6d7035cf9b28a85b31e4fd629a07c
f0593bc8a26e41d7d81c7a9304be6f52
37cb82e61d4fa0956a2fe05d83c914bb
ab0f5d2987e364c1c7e46b1a2d58f930
54e29c7ab1063df81a9b8d05f73ce246
c86d130fe4a27b9540f52ce8b19d763a
0d7ba486f935c21e9e1d7f63a5082cb4
71c8e53a2d0b9f46b36a9021e4c7fd58
e4f0692dc8b5a7135c84be976f012ad3
8b5d1ac7630ef92428f3c15ed97a6b04
26a97f04e1d83bc5d51e2a893b60c7fe
d93c5e81a47f260b6f078db4c21ea953
5fb10c6a98d4e3278ad6f3197e5b240c
a2e84d3f06c175b931c9a5e24df0867b
1b47f9e2b3a60c8de42b781fa63c95d0
c73d0a58f21e96b47d5fe4903bc2a816
680ec39d4b57a1f2a7816cf25e0d943b
fe92b61703ad8c4e125db8e6c97f034a
4d06e8a5c91f7b3293c47a0d18e6bf25
b96a2f3e5d08c4176bf95c31a04e28d7
0374cd81ea6b952fde0613a7f85b49c2
8fe5b02c741d6a397a28f9c4e0d1365b
e0c3718b2f95da4620b3de6915a8c47f
5a9b4e07d6c12f83c5fd07b8639e1a24
94d2c6f9a80e3b1547a1e2d5cb068f93
2f610a5ec73b84d9b8e54f1c0a9d7263
dc5b93a41e7f06286d3c81e792f4b50a
631e7cb205d48af9f2079ab46ce315d8
b4a80f5e9c2d71631e6cd72f85ba904e
0ad79261f3e5bc4893458bc0e17f6a2d
c52f4de8b6a1039e5ab97e132d0c84f6
79e36b04d1f8a25c0fd2a64b98e315c7
e96c1f8a504d37b2b4e803d5c6a72f19
15b8a7c3e2904fd6689f15e2b07dc43a
a8f45d2b7c136e09d74b9c0a13e5f826
4c2a9ef061b5d8733c06e47dfa29b185
f35d071c8e6a924b81adf5364b9ce07d
67b2c84a3fd10e95e59c28b1d470a63f
1c09f3d72ba6e5484e37d9a0c8f162b5
d86e5ab190c34f27a1f06c72e35d948b
32fa1e6c7d8905b4f72e4b9d0a68c1e3
9f46d8352e0ab7c1206b93ce57f4da18
ea18b3c7f64d920e8cd5a7124be06f39
5361fc0ad9b27e84e9a7301f6d2c58b4
bfcd250e8a139f6713f8e6b4c95a0d72
08a3e7d6c45fb12958e24d93a7b1f60c
c72b916d3e40af58a6d3fb0271ce894e

// File: run.sh
#!/bin/sh
# build the fetch testbench with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_fetch -f list.f -o tb_fetch_sim \
	&& ./obj_dir/tb_fetch_sim > sim.log 2>&1 \
	|| { echo "build or simulation error"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "^Simulation PASSED$" sim.log && exit 0 || exit 1

// File: sram_way.sv
`default_nettype none

`include "icache_consts.svh"

module sram_way (
	input logic clk,
	input logic cen_n,
	input logic wen_n,
	input icache_pkg::index_t addr,
	input icache_pkg::line_t din,
	output icache_pkg::line_t dout
);

	import icache_pkg::*;

	// one line per set
	line_t mem [`ICACHE_SETS];

	// registered read data
	line_t dout_q;

	// single port, so a cycle either reads or writes
	always_ff @(posedge clk) begin
		if (!cen_n) begin
			if (!wen_n) begin
				mem[addr] <= din;
				// write-first, new line shows on the read port
				dout_q <= din;
			end else begin
				dout_q <= mem[addr];
			end
		end
	end

	// dout keeps its last value while the chip is deselected
	assign dout = dout_q;

endmodule

`default_nettype wire

// File: tb_checker.sv
`default_nettype none

`include "icache_consts.svh"

module tb_checker (
	input logic clk,
	input logic rst,
	input logic [`ICACHE_ADDR_W-1:0] pc,
	input logic req_valid,
	input logic id_ready,
	input logic flush,
	input icache_pkg::inst_t inst,
	input logic inst_valid,
	output int check_count,
	output int error_count
);

	import icache_pkg::*;

	localparam int MEM_IDX_W = $clog2(`ICACHE_MEM_LINES);

	// reference copy of the program image
	line_t model_mem [`ICACHE_MEM_LINES];

	// prediction for the cycle that follows each rising edge
	logic exp_valid;
	inst_t exp_inst;
	logic armed;
	int checks;
	int errors;

	// addressed word of the reference line, memory wraps every 2 KB
	function automatic inst_t model_word(input logic [`ICACHE_ADDR_W-1:0] addr);
		logic [MEM_IDX_W-1:0] row_idx;
		logic [1:0] word_idx;
		line_t row;
		row_idx = addr[`ICACHE_OFFSET_W +: MEM_IDX_W];
		// four words per line, word 0 in the low bits
		word_idx = addr[3:2];
		row = model_mem[row_idx] >> (word_idx * `ICACHE_INST_W);
		return row[`ICACHE_INST_W-1:0];
	endfunction

	initial begin
		$readmemh("program.hex", model_mem);
		checks = 0;
		errors = 0;
		armed = 1'b0;
		exp_valid = 1'b0;
		exp_inst = '0;
		forever begin
			@(posedge clk);
			// outputs seen during the cycle that just ended
			if (armed) begin
				checks++;
				if (inst_valid !== exp_valid) begin
					errors++;
					$display("FAIL t=%0t inst_valid expected %b actual %b",
						$time, exp_valid, inst_valid);
				end else if (exp_valid && (inst !== exp_inst)) begin
					errors++;
					$display("FAIL t=%0t inst expected %h actual %h",
						$time, exp_inst, inst);
				end
			end
			// next cycle's outputs from the inputs at this edge
			if (rst) begin
				exp_valid = 1'b0;
				armed = 1'b1;
			end else if (id_ready) begin
				exp_valid = req_valid && !flush;
				if (req_valid) begin
					exp_inst = model_word(pc);
				end
			end
			// stalled edges keep the old prediction
		end
	end

	assign check_count = checks;
	assign error_count = errors;

endmodule

`default_nettype wire

// File: tb_fetch.sv
`default_nettype none

`include "icache_consts.svh"

module tb_fetch;

	import icache_pkg::*;

	localparam int PERIOD = 40;
	localparam int RESET_CYCLES = 5;
	localparam int NUM_REQ = 3000;
	localparam int RECENT_N = 8;
	localparam int MEM_BYTES = `ICACHE_MEM_LINES * (`ICACHE_LINE_W / 8);
	// watchdog budget with room for stalls and idle cycles
	localparam int LIMIT = 4 * NUM_REQ * PERIOD + RESET_CYCLES * PERIOD;

	logic clk;
	logic rst;
	logic [`ICACHE_ADDR_W-1:0] pc;
	logic req_valid;
	logic id_ready;
	logic flush;
	inst_t inst;
	logic inst_valid;

	int check_count;
	int error_count;
	int seed_ret;
	int issued;
	int stall_left;

	// recently requested addresses reused to make hits
	logic [`ICACHE_ADDR_W-1:0] recent [RECENT_N];
	logic [2:0] recent_wr;

	fetch_top dut0 (
		.clk(clk),
		.rst(rst),
		.pc(pc),
		.req_valid(req_valid),
		.id_ready(id_ready),
		.flush(flush),
		.inst(inst),
		.inst_valid(inst_valid)
	);

	tb_checker u_checker (
		.clk(clk),
		.rst(rst),
		.pc(pc),
		.req_valid(req_valid),
		.id_ready(id_ready),
		.flush(flush),
		.inst(inst),
		.inst_valid(inst_valid),
		.check_count(check_count),
		.error_count(error_count)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(PERIOD / 2);
			clk = ~clk;
		end
	end

	// word-aligned address inside the program image
	function automatic logic [`ICACHE_ADDR_W-1:0] random_pc();
		logic [`ICACHE_ADDR_W-1:0] r;
		r = $urandom % MEM_BYTES;
		return {r[`ICACHE_ADDR_W-1:2], 2'b00};
	endfunction

	function automatic logic [`ICACHE_ADDR_W-1:0] pick_pc();
		int roll;
		logic [2:0] slot;
		logic [`ICACHE_ADDR_W-1:0] base;
		logic [`ICACHE_ADDR_W-1:0] fresh;
		roll = int'($urandom % 100);
		slot = 3'($urandom % RECENT_N);
		base = recent[slot];
		fresh = random_pc();
		if (roll < 50) begin
			return base;
		end else if (roll < 75) begin
			// same set as a recent address with another tag so ways get evicted
			fresh[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W] =
				base[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
		end
		return fresh;
	endfunction

	// inputs for the next rising edge
	task automatic drive_random();
		if (stall_left > 0) begin
			id_ready = 1'b0;
			stall_left--;
		end else if (($urandom % 100) < 8) begin
			id_ready = 1'b0;
			stall_left = int'($urandom % 5);
		end else begin
			id_ready = 1'b1;
		end
		req_valid = (($urandom % 100) < 85);
		flush = (($urandom % 100) < 3);
		pc = pick_pc();
		if (req_valid) begin
			recent[recent_wr] = pc;
			recent_wr = recent_wr + 3'd1;
		end
	endtask

	initial begin
		rst = 1'b1;
		pc = '0;
		req_valid = 1'b0;
		id_ready = 1'b1;
		flush = 1'b0;
		issued = 0;
		stall_left = 0;
		recent_wr = '0;
		seed_ret = $urandom(32'hc9f);
		for (int i = 0; i < RECENT_N; i++) begin
			recent[i] = random_pc();
		end
		// reset held across the first rising edges
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		// idle cycles before the first request
		repeat (4) @(negedge clk);
		while (issued < NUM_REQ) begin
			drive_random();
			if (req_valid && id_ready) begin
				issued++;
			end
			@(negedge clk);
		end
		// let the last request drain
		req_valid = 1'b0;
		id_ready = 1'b1;
		flush = 1'b0;
		repeat (3) @(negedge clk);
		$display("checked %0d cycles, %0d requests, %0d errors",
			check_count, issued, error_count);
		if (error_count == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(LIMIT);
		$display("timeout: the run did not finish within %0d time units", LIMIT);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire
